// File: include/fxf_macros.svh
`ifndef FXF_MACROS_SVH
`define FXF_MACROS_SVH

// width of the fixed-point input word
`define FXF_WORD_WIDTH 64

// bit that carries the weight one, 27 fraction bits below it
`define FXF_POINT_BIT 27

// single precision exponent bias
`define FXF_EXP_BIAS 127

// stored fraction bits, hidden one excluded
`define FXF_FRAC_WIDTH 23

`endif

// File: logic/fxfPkg.sv
`default_nettype none

`include "fxf_macros.svh"

package fxfPkg;

    typedef enum logic {
        opUnsigned,
        opSigned
    } fxfOpcode;

    typedef enum logic [1:0] {
        stIdle,
        stMeasure,
        stShift,
        stPack
    } convState;

    typedef struct packed {
        fxfOpcode                    opcode;
        logic [`FXF_WORD_WIDTH-1:0]  value;
    } conversionRequest;

    // amount is the distance magnitude, 0 to 36
    typedef struct packed {
        logic       isZero;
        logic       shiftRight;
        logic [5:0] amount;
    } distanceInfo;

    typedef struct packed {
        logic                        sign;
        logic [7:0]                  exponent;
        logic [`FXF_FRAC_WIDTH-1:0]  fraction;
    } floatWord;

endpackage

`default_nettype wire

// File: logic/leadingOneDistance.sv
`default_nettype none

`include "fxf_macros.svh"

module leadingOneDistance (
    input  wire logic [`FXF_WORD_WIDTH-1:0] value,
    output fxfPkg::distanceInfo             distance
);

    logic       upperFound;
    logic [5:0] upperAmount;
    logic       lowerFound;
    logic [5:0] lowerAmount;

    // ones above the binary point, the last hit in the upward scan is the leading one
    always_comb begin
        upperFound = 1'b0;
        upperAmount = '0;
        for (int i = `FXF_POINT_BIT + 1; i < `FXF_WORD_WIDTH; i++) begin
            if (value[i]) begin
                upperFound = 1'b1;
                upperAmount = 6'(i - `FXF_POINT_BIT);
            end
        end
    end

    // at or below the point the distance counts toward bit 0
    always_comb begin
        lowerFound = 1'b0;
        lowerAmount = '0;
        for (int i = 0; i <= `FXF_POINT_BIT; i++) begin
            if (value[i]) begin
                lowerFound = 1'b1;
                lowerAmount = 6'(`FXF_POINT_BIT - i);
            end
        end
    end

    // any one above the point outranks the lower search
    always_comb begin
        distance.isZero = ~(upperFound | lowerFound);
        distance.shiftRight = upperFound;
        if (upperFound) begin
            distance.amount = upperAmount;
        end else begin
            distance.amount = lowerAmount;
        end
    end

endmodule

`default_nettype wire

// File: logic/shiftCounter.sv
`default_nettype none

module shiftCounter (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 loadSteps,
    input  wire                 shiftStep,
    input  wire fxfPkg::distanceInfo distance,
    output logic                finalStep
);

    logic [5:0] stepsLeft;

    always_ff @(posedge clock) begin
        if (reset) begin
            stepsLeft <= '0;
        end else if (loadSteps) begin
            stepsLeft <= distance.amount;
        end else if (shiftStep && stepsLeft != 6'd0) begin
            stepsLeft <= stepsLeft - 6'd1;
        end
    end

    // one step left means the shift in progress is the last
    assign finalStep = (stepsLeft == 6'd1);

endmodule

`default_nettype wire

// File: logic/convControl.sv
`default_nettype none

module convControl (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 start,
    input  wire fxfPkg::distanceInfo distance,
    input  wire                 finalStep,
    output logic                loadValue,
    output logic                captureDistance,
    output logic                loadSteps,
    output logic                shiftStep,
    output logic                packResult,
    output logic                busy,
    output logic                done
);

    import fxfPkg::*;

    convState state;
    convState nextState;
    logic     needShift;

    // already normalized or empty words skip the shifter
    assign needShift = ~distance.isZero && (distance.amount != 6'd0);

    always_comb begin
        nextState = state;
        unique case (state)
            stIdle: begin
                if (start) begin
                    nextState = stMeasure;
                end
            end
            stMeasure: begin
                nextState = needShift ? stShift : stPack;
            end
            stShift: begin
                if (finalStep) begin
                    nextState = stPack;
                end
            end
            stPack: begin
                nextState = stIdle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= stIdle;
            done <= 1'b0;
        end else begin
            state <= nextState;
            done <= (state == stPack);
        end
    end

    // start is only honoured from idle
    assign loadValue = (state == stIdle) && start;
    // the packer needs the measured distance even when no shift follows
    assign captureDistance = (state == stMeasure);
    assign loadSteps = (state == stMeasure) && needShift;
    assign shiftStep = (state == stShift);
    assign packResult = (state == stPack);
    assign busy = (state != stIdle);

endmodule

`default_nettype wire

// File: logic/magnitudeShifter.sv
`default_nettype none

`include "fxf_macros.svh"

module magnitudeShifter (
    input  wire                      clock,
    input  wire                      reset,
    input  wire                      loadValue,
    input  wire                      captureDistance,
    input  wire                      shiftStep,
    input  wire fxfPkg::conversionRequest request,
    input  wire fxfPkg::distanceInfo distance,
    output logic [`FXF_WORD_WIDTH-1:0] magnitude
);

    import fxfPkg::*;

    logic isNegative;
    logic goRight;

    assign isNegative = (request.opcode == opSigned) && request.value[`FXF_WORD_WIDTH-1];

    // direction is held, the live distance drifts as the word moves
    always_ff @(posedge clock) begin
        if (reset) begin
            goRight <= 1'b0;
        end else if (captureDistance) begin
            goRight <= distance.shiftRight;
        end
    end

    // the most negative input wraps to 2^63, which is its true magnitude
    always_ff @(posedge clock) begin
        if (loadValue) begin
            if (isNegative) begin
                magnitude <= -request.value;
            end else begin
                magnitude <= request.value;
            end
        end else if (shiftStep) begin
            if (goRight) begin
                magnitude <= magnitude >> 1;
            end else begin
                magnitude <= magnitude << 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/floatPacker.sv
`default_nettype none

`include "fxf_macros.svh"

module floatPacker (
    input  wire                      clock,
    input  wire                      reset,
    input  wire                      loadValue,
    input  wire                      captureDistance,
    input  wire                      packResult,
    input  wire fxfPkg::conversionRequest request,
    input  wire fxfPkg::distanceInfo distance,
    input  wire logic [`FXF_WORD_WIDTH-1:0] magnitude,
    output fxfPkg::floatWord         result
);

    import fxfPkg::*;

    logic        sign;
    distanceInfo measured;
    logic [7:0]  exponent;

    always_ff @(posedge clock) begin
        if (loadValue) begin
            sign <= (request.opcode == opSigned) && request.value[`FXF_WORD_WIDTH-1];
        end
        if (captureDistance) begin
            measured <= distance;
        end
    end

    // above the point the exponent grows, below it shrinks
    assign exponent = measured.shiftRight ? 8'(`FXF_EXP_BIAS) + {2'b00, measured.amount}
                                          : 8'(`FXF_EXP_BIAS) - {2'b00, measured.amount};

    always_ff @(posedge clock) begin
        if (reset) begin
            result <= '0;
        end else if (packResult) begin
            if (measured.isZero) begin
                result <= '0;
            end else begin
                result.sign <= sign;
                result.exponent <= exponent;
                // hidden one sits at the point, lower bits are truncated
                result.fraction <= magnitude[`FXF_POINT_BIT-1 -: `FXF_FRAC_WIDTH];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/fixedToFloat.sv
`default_nettype none

`include "fxf_macros.svh"

module fixedToFloat (
    input  wire                      clock,
    input  wire                      reset,
    input  wire                      start,
    input  wire fxfPkg::conversionRequest request,
    output logic                     busy,
    output logic                     done,
    output fxfPkg::floatWord         result
);

    import fxfPkg::*;

    logic                       loadValue;
    logic                       captureDistance;
    logic                       loadSteps;
    logic                       shiftStep;
    logic                       packResult;
    logic                       finalStep;
    logic [`FXF_WORD_WIDTH-1:0] magnitude;
    distanceInfo                distance;

    convControl control (
        .clock           (clock),
        .reset           (reset),
        .start           (start),
        .distance        (distance),
        .finalStep       (finalStep),
        .loadValue       (loadValue),
        .captureDistance (captureDistance),
        .loadSteps       (loadSteps),
        .shiftStep       (shiftStep),
        .packResult      (packResult),
        .busy            (busy),
        .done            (done)
    );

    magnitudeShifter shifter (
        .clock           (clock),
        .reset           (reset),
        .loadValue       (loadValue),
        .captureDistance (captureDistance),
        .shiftStep       (shiftStep),
        .request         (request),
        .distance        (distance),
        .magnitude       (magnitude)
    );

    leadingOneDistance search (
        .value    (magnitude),
        .distance (distance)
    );

    shiftCounter counter (
        .clock     (clock),
        .reset     (reset),
        .loadSteps (loadSteps),
        .shiftStep (shiftStep),
        .distance  (distance),
        .finalStep (finalStep)
    );

    floatPacker packer (
        .clock           (clock),
        .reset           (reset),
        .loadValue       (loadValue),
        .captureDistance (captureDistance),
        .packResult      (packResult),
        .request         (request),
        .distance        (distance),
        .magnitude       (magnitude),
        .result          (result)
    );

endmodule

`default_nettype wire

// File: verif/fixedToFloatTb.sv
`default_nettype none

`include "fxf_macros.svh"

module fixedToFloatTb;

    import fxfPkg::*;

    localparam int resetCycles = 10;
    // zero, powers, signed, truncation, ignored start and random conversions
    localparam int numConversions = 2 + 64 + 6 + 6 + 2 + 200;
    localparam int cyclesPerConversion = 40;
    localparam int doneLimit = 80;

    logic             clock;
    logic             reset;
    logic             start;
    conversionRequest request;
    logic             busy;
    logic             done;
    floatWord         result;
    int               errorCount = 0;
    int               seed = 32'h3d79_691c;
    convState         stateAtTimeout;

    fixedToFloat UUT (
        .clock   (clock),
        .reset   (reset),
        .start   (start),
        .request (request),
        .busy    (busy),
        .done    (done),
        .result  (result)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic conversionRequest makeRequest(fxfOpcode op,
                                                     logic [`FXF_WORD_WIDTH-1:0] value);
        conversionRequest req;
        req.opcode = op;
        req.value = value;
        return req;
    endfunction

    function automatic logic [`FXF_WORD_WIDTH-1:0] magnitudeOf(conversionRequest req);
        if (req.opcode == opSigned && req.value[`FXF_WORD_WIDTH-1]) begin
            return -req.value;
        end
        return req.value;
    endfunction

    // index of the highest one bit, -1 for an empty word
    function automatic int leadingIndex(logic [`FXF_WORD_WIDTH-1:0] mag);
        int idx;
        idx = -1;
        for (int i = 0; i < `FXF_WORD_WIDTH; i++) begin
            if (mag[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic floatWord expectedFloat(conversionRequest req);
        logic [`FXF_WORD_WIDTH-1:0] mag;
        logic [`FXF_WORD_WIDTH-1:0] norm;
        int                         idx;
        floatWord                   word;
        mag = magnitudeOf(req);
        idx = leadingIndex(mag);
        word = '0;
        if (idx >= 0) begin
            // leading one moved to the top, the next 23 bits are kept
            norm = mag << (`FXF_WORD_WIDTH - 1 - idx);
            word.sign = (req.opcode == opSigned) && req.value[`FXF_WORD_WIDTH-1];
            word.exponent = 8'(`FXF_EXP_BIAS + idx - `FXF_POINT_BIT);
            word.fraction = norm[`FXF_WORD_WIDTH-2 -: `FXF_FRAC_WIDTH];
        end
        return word;
    endfunction

    function automatic int expectedLatency(conversionRequest req);
        int idx;
        idx = leadingIndex(magnitudeOf(req));
        if (idx < 0) begin
            return 3;
        end
        return ((idx > `FXF_POINT_BIT) ? idx - `FXF_POINT_BIT : `FXF_POINT_BIT - idx) + 3;
    endfunction

    task automatic checkFloat(input string name, input floatWord expected,
                              input floatWord actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkLatency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            errorCount++;
            $display("Fail %s: expected latency %0d actual latency %0d", name, expected, actual);
        end
    endtask

    task automatic protocolError(input string what);
        errorCount++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // returns just after edge 0, the edge that samples start
    task automatic startConversion(input conversionRequest req);
        @(posedge clock);
        start <= 1'b1;
        request <= req;
        @(posedge clock);
        start <= 1'b0;
    endtask

    // firstCount is the latency that a done seen at the next negedge would mean
    task automatic waitForDone(input string name, input int firstCount,
                               output int cycles, output bit seen);
        bit waiting;
        cycles = firstCount;
        seen = 1'b0;
        waiting = 1'b1;
        while (waiting) begin
            @(negedge clock);
            if (done) begin
                seen = 1'b1;
                waiting = 1'b0;
                if (busy) begin
                    protocolError($sformatf("%s: busy still high while done is high", name));
                end
            end else if (!busy) begin
                protocolError($sformatf("%s: busy dropped without a done pulse", name));
                waiting = 1'b0;
            end else if (cycles >= doneLimit) begin
                protocolError($sformatf("%s: done never arrived", name));
                waiting = 1'b0;
            end else begin
                @(posedge clock);
                cycles++;
            end
        end
    endtask

    task automatic runConversion(input string name, input conversionRequest req,
                                 input floatWord expected);
        int cycles;
        bit seen;
        startConversion(req);
        waitForDone(name, 1, cycles, seen);
        if (seen) begin
            checkFloat(name, expected, result);
            checkLatency(name, expectedLatency(req), cycles);
        end
    endtask

    task automatic testResetAndZero;
        @(negedge clock);
        if (busy || done) begin
            protocolError("busy or done is high right after reset");
        end
        checkFloat("reset value", '0, result);
        runConversion("zero unsigned", makeRequest(opUnsigned, '0), '0);
        runConversion("zero signed", makeRequest(opSigned, '0), '0);
    endtask

    task automatic testPowers;
        conversionRequest req;
        for (int i = 0; i < `FXF_WORD_WIDTH; i++) begin
            req = makeRequest(opUnsigned, 64'd1 << i);
            runConversion($sformatf("power %0d", i), req, expectedFloat(req));
        end
    endtask

    task automatic testSigned;
        conversionRequest req;
        runConversion("minus one", makeRequest(opSigned, 64'hFFFF_FFFF_F800_0000), 32'hBF80_0000);
        runConversion("minus 2^36", makeRequest(opSigned, 64'hFFFF_FFF0_0000_0000), 32'hC400_0000);
        runConversion("most negative", makeRequest(opSigned, 64'h8000_0000_0000_0000),
                      32'hD180_0000);
        // same bit patterns read as unsigned stay positive
        req = makeRequest(opUnsigned, 64'hFFFF_FFFF_F800_0000);
        runConversion("minus one unsigned", req, expectedFloat(req));
        req = makeRequest(opUnsigned, 64'hFFFF_FFF0_0000_0000);
        runConversion("minus 2^36 unsigned", req, expectedFloat(req));
        req = makeRequest(opUnsigned, 64'h8000_0000_0000_0000);
        runConversion("most negative unsigned", req, expectedFloat(req));
    endtask

    task automatic testTruncation;
        conversionRequest req;
        req = makeRequest(opUnsigned, 64'h0000_0000_0FFF_FFFF);
        runConversion("trunc at point", req, expectedFloat(req));
        req = makeRequest(opUnsigned, 64'h0000_0000_07FF_FFFF);
        runConversion("trunc below point", req, expectedFloat(req));
        req = makeRequest(opUnsigned, 64'h0000_0123_4567_89AB);
        runConversion("trunc above point", req, expectedFloat(req));
        req = makeRequest(opUnsigned, 64'h7FFF_FFFF_FFFF_FFFF);
        runConversion("trunc all ones", req, expectedFloat(req));
        req = makeRequest(opSigned, 64'hF123_4567_89AB_CDEF);
        runConversion("trunc negative", req, expectedFloat(req));
        req = makeRequest(opSigned, 64'h0000_0000_04D2_C3B1);
        runConversion("trunc positive signed", req, expectedFloat(req));
    endtask

    task automatic testIgnoredStart;
        conversionRequest first;
        conversionRequest second;
        int               cycles;
        bit               seen;
        // bit 0 needs 27 shifts, so the second start lands mid conversion
        first = makeRequest(opUnsigned, 64'h1);
        second = makeRequest(opSigned, 64'hFFFF_FFFF_F800_0000);
        startConversion(first);
        repeat (4) @(posedge clock);
        start <= 1'b1;
        request <= second;
        @(posedge clock);
        start <= 1'b0;
        waitForDone("ignored start", 6, cycles, seen);
        if (seen) begin
            checkFloat("ignored start", expectedFloat(first), result);
            checkLatency("ignored start", expectedLatency(first), cycles);
            repeat (50) begin
                @(negedge clock);
                if (done) begin
                    protocolError("a second done pulse followed the ignored start");
                end
            end
            checkFloat("ignored start held", expectedFloat(first), result);
        end
    endtask

    task automatic testRandom;
        conversionRequest           req;
        logic [`FXF_WORD_WIDTH-1:0] raw;
        int                         pos;
        fxfOpcode                   op;
        for (int i = 0; i < 200; i++) begin
            raw = {$random(seed), $random(seed)};
            pos = $unsigned($random(seed)) % `FXF_WORD_WIDTH;
            op = ($random(seed) & 1) ? opSigned : opUnsigned;
            req = makeRequest(op, (raw & ((64'd1 << pos) - 64'd1)) | (64'd1 << pos));
            runConversion($sformatf("random %0d", i), req, expectedFloat(req));
        end
    endtask

    initial begin
        reset <= 1'b1;
        start <= 1'b0;
        request <= '0;
        repeat (resetCycles) @(posedge clock);
        reset <= 1'b0;
        testResetAndZero();
        testPowers();
        testSigned();
        testTruncation();
        testIgnoredStart();
        testRandom();
        $display("%0d errors", errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (resetCycles + numConversions * cyclesPerConversion) @(posedge clock);
        stateAtTimeout = UUT.control.state;
        $display("timeout: conversions still running, converter state %s",
                 stateAtTimeout.name());
        $display("%0d errors", errorCount);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
logic/fxfPkg.sv
logic/leadingOneDistance.sv
logic/shiftCounter.sv
logic/convControl.sv
logic/magnitudeShifter.sv
logic/floatPacker.sv
logic/fixedToFloat.sv
verif/fixedToFloatTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fixedToFloatTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
